//--- all.f
hw/l2wb_pkg.sv
hw/axi_wr_pkg.sv
hw/write_buffer.sv
hw/write_fsm.sv
hw/write_channel_driver.sv
hw/l2_write_path.sv
dv/mem_port_model.sv
dv/tb_l2_write_path.sv

//--- dv/mem_port_model.sv
`default_nettype none

module mem_port_model (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic [1:0]      mode,              // 0 always ready, 1 random stalls, 2 hold.
    input  wire logic            awvalid,
    input  wire axi_wr_pkg::aw_t aw,
    output logic                 awready,
    input  wire logic            wvalid,
    input  wire axi_wr_pkg::w_t  w,
    output logic                 wready,
    output logic                 bvalid,
    input  wire logic            bready,
    output logic                 cap_valid,         // one cycle per completed write.
    output l2wb_pkg::addr_t      cap_addr,
    output axi_wr_pkg::len_t     cap_len,
    output logic [3:0]           cap_beats,
    output l2wb_pkg::line_t      cap_line,
    output logic                 cap_last_ok
);
    import l2wb_pkg::*;
    import axi_wr_pkg::*;

    int   seed = 30;
    int   rnd;
    logic resp_pend;                                // data done, response not yet raised.
    logic w_end;

    function automatic logic gate(input logic [1:0] m, input int r);
        case (m)
            2'd1:    return r[0];
            2'd2:    return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    assign w_end = w.last || (cap_beats == cap_len[3:0]);

    always @(posedge clk) begin
        rnd = $random(seed);
        if (!rstn) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            resp_pend <= 1'b0;
            cap_valid <= 1'b0;
        end else begin
            awready   <= gate(mode, rnd);
            wready    <= gate(mode, rnd >> 1);
            cap_valid <= bvalid && bready;          // record closes with the response.
            if (awvalid && awready) begin
                cap_addr    <= aw.addr;
                cap_len     <= aw.len;
                cap_beats   <= '0;
                cap_last_ok <= 1'b1;
            end
            if (wvalid && wready) begin
                cap_line[cap_beats[2:0]] <= w.data;
                cap_beats <= cap_beats + 4'd1;
                if (w.last != (cap_beats == cap_len[3:0])) cap_last_ok <= 1'b0;
                if (w_end) resp_pend <= 1'b1;
            end
            if (resp_pend && !bvalid && gate(mode, rnd >> 2)) begin
                bvalid    <= 1'b1;
                resp_pend <= 1'b0;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_l2_write_path.sv
`default_nettype none

module tb_l2_write_path;
    import l2wb_pkg::*;
    import axi_wr_pkg::*;

    localparam int ROWS        = 14;
    localparam int CYCLE_LIMIT = ROWS * 40 + 200;

    typedef enum logic [1:0] {STALL_NONE, STALL_RAND, STALL_HOLD} stall_e;

    typedef struct packed {
        logic   dma;
        addr_t  addr;
        word_t  base;                               // word i of the line is base + i.
        stall_e stall;
        logic   sync;                               // wait for all earlier writes first.
    } row_t;

    logic       clk;
    logic       rstn;
    logic       wr_valid;
    wr_req_t    wr_req;
    logic       wbuf_full;
    logic       dma_idle;
    stall_e     stall;
    logic       out_awvalid;
    aw_t        out_aw;
    logic       out_awready;
    logic       out_wvalid;
    w_t         out_w;
    logic       out_wready;
    logic       out_bvalid;
    logic       out_bready;
    logic       l2_awvalid;
    aw_t        l2_aw;
    logic       l2_awready;
    logic       l2_wvalid;
    w_t         l2_w;
    logic       l2_wready;
    logic       l2_bvalid;
    logic       l2_bready;
    logic       out_cap_valid;
    addr_t      out_cap_addr;
    len_t       out_cap_len;
    logic [3:0] out_cap_beats;
    line_t      out_cap_line;
    logic       out_cap_last_ok;
    logic       l2_cap_valid;
    addr_t      l2_cap_addr;
    len_t       l2_cap_len;
    logic [3:0] l2_cap_beats;
    line_t      l2_cap_line;
    logic       l2_cap_last_ok;

    row_t rows [ROWS];
    row_t out_exp_q [$];
    row_t l2_exp_q [$];
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   occ = 0;                                  // lines the buffer should hold.
    int   out_sent = 0;
    int   l2_sent = 0;
    int   out_done = 0;
    int   l2_done = 0;
    logic saw_full = 1'b0;

    l2_write_path DUT (.*);

    mem_port_model mem_model (
        .clk (clk), .rstn (rstn), .mode (stall),
        .awvalid (out_awvalid), .aw (out_aw), .awready (out_awready),
        .wvalid (out_wvalid), .w (out_w), .wready (out_wready),
        .bvalid (out_bvalid), .bready (out_bready),
        .cap_valid (out_cap_valid), .cap_addr (out_cap_addr), .cap_len (out_cap_len),
        .cap_beats (out_cap_beats), .cap_line (out_cap_line), .cap_last_ok (out_cap_last_ok)
    );

    mem_port_model dma_model (
        .clk (clk), .rstn (rstn), .mode (stall),
        .awvalid (l2_awvalid), .aw (l2_aw), .awready (l2_awready),
        .wvalid (l2_wvalid), .w (l2_w), .wready (l2_wready),
        .bvalid (l2_bvalid), .bready (l2_bready),
        .cap_valid (l2_cap_valid), .cap_addr (l2_cap_addr), .cap_len (l2_cap_len),
        .cap_beats (l2_cap_beats), .cap_line (l2_cap_line), .cap_last_ok (l2_cap_last_ok)
    );

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic line_t make_line(input word_t base);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) l[i] = base + word_t'(i);
        return l;
    endfunction

    task automatic compare_write(input string port, input row_t r, input addr_t addr,
                                 input len_t len, input logic [3:0] beats,
                                 input line_t line, input logic last_ok);
        int n;
        n = r.dma ? 1 : LINE_WORDS;
        check({port, " address"}, addr, r.addr);
        check({port, " len"}, len, r.dma ? SINGLE_LEN : BURST_LEN);
        check({port, " beat count"}, beats, n);
        check({port, " last only on final beat"}, last_ok, 1'b1);
        for (int i = 0; i < n; i++) check({port, " data word"}, line[i], r.base + word_t'(i));
    endtask

    function automatic logic drained();
        return out_done == out_sent && l2_done == l2_sent && occ == 0 && dma_idle;
    endfunction

    task automatic apply_row(input row_t r);
        if (r.sync) while (!drained()) @(negedge clk);
        stall <= r.stall;
        @(negedge clk);
        // a dma request needs an empty buffer or the drain leaves IDLE at the same edge.
        if (r.dma) while (!(dma_idle && occ == 0)) @(negedge clk);
        else while (wbuf_full) @(negedge clk);
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_req   <= '{addr: r.addr, line: make_line(r.base), dma: r.dma};
        if (r.dma) l2_sent = l2_sent + 1;
        else out_sent = out_sent + 1;
        @(posedge clk);
        wr_valid <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // buffer occupancy follows pushes and burst responses.
    always @(posedge clk) begin
        if (rstn) begin
            check("wbuf_full", wbuf_full, occ == WBUF_DEPTH);
            if (wbuf_full) saw_full <= 1'b1;
            occ <= occ + ((wr_valid && !wr_req.dma) ? 1 : 0)
                       - ((out_bvalid && out_bready) ? 1 : 0);
        end
    end

    always @(posedge clk) begin
        if (out_cap_valid) begin
            out_done <= out_done + 1;
            if (out_exp_q.size() == 0) begin
                errors = errors + 1;
                $display("unexpected write to address %h on the memory port", out_cap_addr);
            end else begin
                compare_write("memory port", out_exp_q.pop_front(), out_cap_addr, out_cap_len,
                              out_cap_beats, out_cap_line, out_cap_last_ok);
            end
        end
    end

    always @(posedge clk) begin
        if (l2_cap_valid) begin
            l2_done <= l2_done + 1;
            if (l2_exp_q.size() == 0) begin
                errors = errors + 1;
                $display("unexpected write to address %h on the dma port", l2_cap_addr);
            end else begin
                compare_write("dma port", l2_exp_q.pop_front(), l2_cap_addr, l2_cap_len,
                              l2_cap_beats, l2_cap_line, l2_cap_last_ok);
            end
        end
    end

    initial begin
        rstn     = 1'b0;
        wr_valid = 1'b0;
        wr_req   = '0;
        stall    = STALL_NONE;
        //          dma   addr          base          stall       sync
        rows[0]  = '{1'b0, 32'h0000_1000, 32'h1000_0000, STALL_NONE, 1'b0};
        rows[1]  = '{1'b1, 32'h0000_2004, 32'h2000_0000, STALL_NONE, 1'b0};
        rows[2]  = '{1'b0, 32'h0000_1020, 32'h1100_0000, STALL_NONE, 1'b0};
        rows[3]  = '{1'b0, 32'h0000_3000, 32'h3000_0000, STALL_HOLD, 1'b1};
        rows[4]  = '{1'b0, 32'h0000_3020, 32'h3100_0000, STALL_HOLD, 1'b0};
        rows[5]  = '{1'b0, 32'h0000_3040, 32'h3200_0000, STALL_HOLD, 1'b0};
        rows[6]  = '{1'b0, 32'h0000_3060, 32'h3300_0000, STALL_HOLD, 1'b0};
        rows[7]  = '{1'b1, 32'h0000_4008, 32'h4000_0000, STALL_NONE, 1'b0};
        rows[8]  = '{1'b0, 32'h0000_5000, 32'h5000_0000, STALL_RAND, 1'b0};
        rows[9]  = '{1'b1, 32'h0000_6000, 32'h6000_0000, STALL_RAND, 1'b0};
        rows[10] = '{1'b0, 32'h0000_5020, 32'h5100_0000, STALL_RAND, 1'b0};
        rows[11] = '{1'b0, 32'h0000_5040, 32'h5200_0000, STALL_RAND, 1'b0};
        rows[12] = '{1'b1, 32'h0000_600c, 32'h6100_0000, STALL_RAND, 1'b0};
        rows[13] = '{1'b0, 32'h0000_5060, 32'h5300_0000, STALL_RAND, 1'b0};
        for (int i = 0; i < ROWS; i++) begin
            if (rows[i].dma) l2_exp_q.push_back(rows[i]);
            else out_exp_q.push_back(rows[i]);
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check("valids, readies, full and dma_idle after reset",
              {out_awvalid, out_wvalid, out_bready, l2_awvalid, l2_wvalid, l2_bready,
               wbuf_full, dma_idle}, 8'b0000_0001);
        for (int i = 0; i < ROWS; i++) apply_row(rows[i]);
        while (!drained()) @(negedge clk);
        repeat (4) @(negedge clk);
        check("buffer reached full under stall", saw_full, 1'b1);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

    localparam int LEN_W = 8;

    typedef logic [LEN_W-1:0] len_t;                 // beats minus one.

    localparam len_t BURST_LEN  = len_t'(l2wb_pkg::LINE_WORDS - 1);
    localparam len_t SINGLE_LEN = '0;

    // write address channel payload
    typedef struct packed {
        l2wb_pkg::addr_t addr;
        len_t            len;
    } aw_t;

    // write data channel payload
    typedef struct packed {
        l2wb_pkg::word_t data;
        logic            last;                       // final beat of the burst.
    } w_t;

endpackage

`default_nettype wire

//--- hw/l2_write_path.sv
`default_nettype none

module l2_write_path (
    input  wire logic              clk,
    input  wire logic              rstn,
    // requester side
    input  wire logic              wr_valid,
    input  wire l2wb_pkg::wr_req_t wr_req,
    output logic                   wbuf_full,
    output logic                   dma_idle,
    // memory port
    output logic                   out_awvalid,
    output axi_wr_pkg::aw_t        out_aw,
    input  wire logic              out_awready,
    output logic                   out_wvalid,
    output axi_wr_pkg::w_t         out_w,
    input  wire logic              out_wready,
    input  wire logic              out_bvalid,
    output logic                   out_bready,
    // dma port
    output logic                   l2_awvalid,
    output axi_wr_pkg::aw_t        l2_aw,
    input  wire logic              l2_awready,
    output logic                   l2_wvalid,
    output axi_wr_pkg::w_t         l2_w,
    input  wire logic              l2_wready,
    input  wire logic              l2_bvalid,
    output logic                   l2_bready
);
    import l2wb_pkg::*;

    wire logic      wb_push;                         // writeback into the buffer.
    wire logic      wb_pop;
    wire wr_req_t   wb_head;
    wire wbuf_cnt_t wb_count;
    wire wr_state_e wr_state;

    assign wb_push = wr_valid && !wr_req.dma;

    write_buffer u_write_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .push     (wb_push),
        .push_req (wr_req),
        .pop      (wb_pop),
        .head     (wb_head),
        .count    (wb_count),
        .full     (wbuf_full)
    );

    write_fsm u_write_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (wr_valid),
        .req_dma     (wr_req.dma),
        .count       (wb_count),
        .out_awready (out_awready),
        .out_wready  (out_wready),
        .out_bvalid  (out_bvalid),
        .l2_awready  (l2_awready),
        .l2_wready   (l2_wready),
        .l2_bvalid   (l2_bvalid),
        .state       (wr_state)
    );

    write_channel_driver u_write_channel_driver (
        .clk         (clk),
        .rstn        (rstn),
        .state       (wr_state),
        .req_valid   (wr_valid),
        .req         (wr_req),
        .head        (wb_head),
        .out_bvalid  (out_bvalid),
        .l2_bvalid   (l2_bvalid),
        .out_awvalid (out_awvalid),
        .out_aw      (out_aw),
        .out_wvalid  (out_wvalid),
        .out_w       (out_w),
        .out_bready  (out_bready),
        .l2_awvalid  (l2_awvalid),
        .l2_aw       (l2_aw),
        .l2_wvalid   (l2_wvalid),
        .l2_w        (l2_w),
        .l2_bready   (l2_bready),
        .pop         (wb_pop),
        .dma_idle    (dma_idle)
    );

endmodule

`default_nettype wire

//--- hw/l2wb_pkg.sv
`default_nettype none

package l2wb_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;                   // words per line and beats per burst.
    localparam int WBUF_DEPTH = 4;                   // write buffer entries.
    localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);
    localparam int BEAT_W     = $clog2(LINE_WORDS);

    typedef logic [ADDR_W-1:0]      addr_t;          // byte address.
    typedef logic [WORD_W-1:0]      word_t;
    typedef word_t [LINE_WORDS-1:0] line_t;          // word 0 in the low bits.
    typedef logic [WBUF_PTR_W-1:0]  wbuf_ptr_t;
    typedef logic [WBUF_PTR_W:0]    wbuf_cnt_t;      // holds 0 to WBUF_DEPTH.
    typedef logic [BEAT_W-1:0]      beat_t;

    typedef struct packed {
        addr_t addr;
        line_t line;
        logic  dma;                                  // set for an uncached single write.
    } wr_req_t;

    typedef enum logic [3:0] {
        IDLE, DMA_AW, DMA_W, DMA_R, PULL,
        SEND_0, SEND_1, SEND_2, SEND_3,
        SEND_4, SEND_5, SEND_6, SEND_7,
        SEND_END
    } wr_state_e;

endpackage

`default_nettype wire

//--- hw/write_buffer.sv
`default_nettype none

module write_buffer (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                push,
    input  wire l2wb_pkg::wr_req_t   push_req,
    input  wire logic                pop,
    output l2wb_pkg::wr_req_t        head,
    output l2wb_pkg::wbuf_cnt_t      count,
    output logic                     full
);
    import l2wb_pkg::*;

    wr_req_t   mem [WBUF_DEPTH];                     // dirty line storage.
    wbuf_ptr_t wr_ptr;
    wbuf_ptr_t rd_ptr;

    function automatic wbuf_ptr_t ptr_inc(input wbuf_ptr_t ptr);
        if (ptr == wbuf_ptr_t'(WBUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // both or neither.
            endcase
        end
    end

    assign head = mem[rd_ptr];                       // oldest line.
    assign full = (count == wbuf_cnt_t'(WBUF_DEPTH));

    // requester must hold writebacks while wbuf_full is high
    push_not_full: assert property (
        @(posedge clk) disable iff (!rstn) push |-> !full
    ) else $error("write_buffer: writeback presented while full");

    // the drain only completes a burst that came from a real entry
    pop_not_empty: assert property (
        @(posedge clk) disable iff (!rstn) pop |-> (count != '0)
    ) else $error("write_buffer: pop while empty");

endmodule

`default_nettype wire

//--- hw/write_channel_driver.sv
`default_nettype none

module write_channel_driver (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire l2wb_pkg::wr_state_e state,
    input  wire logic                req_valid,
    input  wire l2wb_pkg::wr_req_t   req,
    input  wire l2wb_pkg::wr_req_t   head,
    input  wire logic                out_bvalid,
    input  wire logic                l2_bvalid,
    output logic                     out_awvalid,
    output axi_wr_pkg::aw_t          out_aw,
    output logic                     out_wvalid,
    output axi_wr_pkg::w_t           out_w,
    output logic                     out_bready,
    output logic                     l2_awvalid,
    output axi_wr_pkg::aw_t          l2_aw,
    output logic                     l2_wvalid,
    output axi_wr_pkg::w_t           l2_w,
    output logic                     l2_bready,
    output logic                     pop,
    output logic                     dma_idle
);
    import l2wb_pkg::*;
    import axi_wr_pkg::*;

    addr_t dma_addr;                                 // latched dma target.
    word_t dma_word;                                 // word 0 of the dma line.
    logic  dma_held;
    logic  dma_take;
    beat_t beat;

    assign dma_take = (state == IDLE) && req_valid && req.dma;

    always_ff @(posedge clk) begin
        if (dma_take) begin
            dma_addr <= req.addr;
            dma_word <= req.line[0];
        end
    end

    // marks that the latch holds a request not yet answered
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dma_held <= 1'b0;
        end else if (dma_take) begin
            dma_held <= 1'b1;
        end else if ((state == DMA_R) && l2_bvalid) begin
            dma_held <= 1'b0;
        end
    end

    always_comb begin
        case (state)
            SEND_1:  beat = beat_t'(1);
            SEND_2:  beat = beat_t'(2);
            SEND_3:  beat = beat_t'(3);
            SEND_4:  beat = beat_t'(4);
            SEND_5:  beat = beat_t'(5);
            SEND_6:  beat = beat_t'(6);
            SEND_7:  beat = beat_t'(7);
            default: beat = '0;                      // SEND_0 and all other states.
        endcase
    end

    assign out_awvalid = (state == PULL);
    assign out_aw      = '{addr: head.addr, len: BURST_LEN};
    assign out_wvalid  = state inside {[SEND_0:SEND_7]};
    assign out_w       = '{data: head.line[beat], last: (state == SEND_7)};
    assign out_bready  = (state == SEND_END);
    assign pop         = (state == SEND_END) && out_bvalid;

    assign l2_awvalid  = (state == DMA_AW);
    assign l2_aw       = '{addr: dma_addr, len: SINGLE_LEN};
    assign l2_wvalid   = (state == DMA_W);
    assign l2_w        = '{data: dma_word, last: 1'b1};
    assign l2_bready   = (state == DMA_R);

    assign dma_idle    = (state == IDLE);

    // the fsm must start the dma sequence right after the latch captures
    dma_starts: assert property (
        @(posedge clk) disable iff (!rstn) dma_take |=> (state == DMA_AW)
    ) else $error("write_channel_driver: dma request not started");

    dma_aw_latched: assert property (
        @(posedge clk) disable iff (!rstn) l2_awvalid |-> dma_held
    ) else $error("write_channel_driver: dma address without a latched request");

endmodule

`default_nettype wire

//--- hw/write_fsm.sv
`default_nettype none

module write_fsm (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                req_valid,
    input  wire logic                req_dma,
    input  wire l2wb_pkg::wbuf_cnt_t count,
    input  wire logic                out_awready,
    input  wire logic                out_wready,
    input  wire logic                out_bvalid,
    input  wire logic                l2_awready,
    input  wire logic                l2_wready,
    input  wire logic                l2_bvalid,
    output l2wb_pkg::wr_state_e      state
);
    import l2wb_pkg::*;

    wr_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;                          // hold while waiting on a handshake.
        case (state)
            IDLE: begin
                if (req_valid) begin
                    if (req_dma) begin
                        next_state = DMA_AW;
                    end
                end else if (count != '0) begin
                    next_state = PULL;               // drain only when no request is present.
                end
            end
            DMA_AW: begin
                if (l2_awready) next_state = DMA_W;
            end
            DMA_W: begin
                if (l2_wready) next_state = DMA_R;
            end
            DMA_R: begin
                if (l2_bvalid) next_state = IDLE;
            end
            PULL: begin
                if (out_awready) next_state = SEND_0;
            end
            SEND_0: begin
                if (out_wready) next_state = SEND_1;
            end
            SEND_1: begin
                if (out_wready) next_state = SEND_2;
            end
            SEND_2: begin
                if (out_wready) next_state = SEND_3;
            end
            SEND_3: begin
                if (out_wready) next_state = SEND_4;
            end
            SEND_4: begin
                if (out_wready) next_state = SEND_5;
            end
            SEND_5: begin
                if (out_wready) next_state = SEND_6;
            end
            SEND_6: begin
                if (out_wready) next_state = SEND_7;
            end
            SEND_7: begin
                if (out_wready) next_state = SEND_END;
            end
            SEND_END: begin
                if (out_bvalid) next_state = IDLE;  // response frees the buffer slot.
            end
            default: next_state = IDLE;
        endcase
    end

    // dma requests are only legal while dma_idle is high
    dma_req_in_idle: assert property (
        @(posedge clk) disable iff (!rstn) (req_valid && req_dma) |-> (state == IDLE)
    ) else $error("write_fsm: dma request outside IDLE");

    state_legal: assert property (
        @(posedge clk) disable iff (!rstn) state inside {[IDLE:SEND_END]}
    ) else $error("write_fsm: illegal state encoding");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it into sim.log and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_l2_write_path -o sim_l2_write_path \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_l2_write_path > sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
